// ==== logic/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

////////////////////////////////////////////////////////////
// Core widths
////////////////////////////////////////////////////////////

// Data and address width
`define CORE_XLEN 32

// Retirement order counter width
`define CORE_ORDER_W 64

// Killed instruction counter width
`define CORE_KILL_W 16

////////////////////////////////////////////////////////////
// Trap handling
////////////////////////////////////////////////////////////

// Next PC reported by a trapping instruction, word aligned
`define CORE_TRAP_VECTOR 32'h0000_0100

`endif

// ==== logic/core_pkg.sv ====
`include "core_config.svh"

package core_pkg;

    ////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////

    // Instruction words, PCs, register data and addresses
    typedef logic [`CORE_XLEN-1:0] word_t;

    // Integer register index
    typedef logic [4:0] reg_addr_t;

    // Byte mask of a 32-bit data access
    typedef logic [3:0] byte_en_t;

    // Retirement order number
    typedef logic [`CORE_ORDER_W-1:0] order_t;

    // Number of instructions killed by redirects
    typedef logic [`CORE_KILL_W-1:0] kill_cnt_t;

    ////////////////////////////////////////////////////////////
    // Pipeline control FSM
    ////////////////////////////////////////////////////////////

    // RUN           normal flow
    // MEM_WAIT      MEM access held by a busy memory
    // TRAP_ENTRY    trap seen, next survivor is the handler entry
    typedef enum logic [1:0] {
        CTRL_RUN        = 2'd0,
        CTRL_MEM_WAIT   = 2'd1,
        CTRL_TRAP_ENTRY = 2'd2
    } ctrl_state_t;

endpackage

// ==== logic/pipe_ctrl_fsm.sv ====
`timescale 1ns/1ps

module pipe_ctrl_fsm import core_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,

    // Status from the shadow pipeline
    input  logic        ex_redirect_i,
    input  logic        ex_is_trap_i,
    input  logic        mem_is_access_i,

    // Memory and source status
    input  logic        mem_busy_i,
    input  logic        id_valid_i,

    // Pipeline controls
    output logic        pipe_stall_o,
    output logic        ex_flush_o,
    output logic        wb_bubble_o,
    output logic        mark_intr_o,
    output logic        kill_o,

    // Current state, observed by the checker
    output ctrl_state_t state_o
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        kill_pend_q;
    logic        trap_redirect;
    logic        accept;

    ////////////////////////////////////////////////////////////
    // Combinational controls
    ////////////////////////////////////////////////////////////

    // A busy memory freezes ID, EX and MEM
    assign pipe_stall_o = mem_is_access_i && mem_busy_i;

    // Kill the instruction entering EX behind a redirect,
    // or the first one accepted later if ID was empty then
    assign ex_flush_o = (ex_redirect_i || kill_pend_q) && !pipe_stall_o;

    // WB sees bubbles while MEM is held
    assign wb_bubble_o = pipe_stall_o;

    assign kill_o = ex_flush_o && id_valid_i;

    // Trap leaves EX on this edge
    assign trap_redirect = ex_redirect_i && ex_is_trap_i && !pipe_stall_o;

    // Acceptance of an instruction that survives
    assign accept = id_valid_i && !pipe_stall_o && !ex_flush_o;

    assign mark_intr_o = (state_q == CTRL_TRAP_ENTRY);
    assign state_o     = state_q;

    ////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_RUN, CTRL_MEM_WAIT: begin
                if (trap_redirect) begin
                    state_d = CTRL_TRAP_ENTRY;
                end else if (pipe_stall_o) begin
                    state_d = CTRL_MEM_WAIT;
                end else begin
                    state_d = CTRL_RUN;
                end
            end
            CTRL_TRAP_ENTRY: begin
                // Stay until the handler's first instruction gets in
                if (accept) begin
                    state_d = CTRL_RUN;
                end
            end
            default: begin
                state_d = CTRL_RUN;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // State registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= CTRL_RUN;
            kill_pend_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Pending kill survives until a valid ID instruction is flushed
            if (ex_flush_o) begin
                kill_pend_q <= !id_valid_i;
            end
        end
    end

endmodule

// ==== logic/retire_counter.sv ====
`timescale 1ns/1ps

module retire_counter import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,

    // Strobes
    input  logic      retire_i,
    input  logic      kill_i,

    // Counts
    output order_t    order_o,
    output kill_cnt_t kill_count_o
);

    order_t    order_q;
    kill_cnt_t kill_q;

    // Record in WB carries the number of earlier retirements
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            order_q <= '0;
        end else if (retire_i) begin
            order_q <= order_q + order_t'(1);
        end
    end

    // Saturating kill count
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            kill_q <= '0;
        end else if (kill_i && (kill_q != '1)) begin
            kill_q <= kill_q + kill_cnt_t'(1);
        end
    end

    assign order_o      = order_q;
    assign kill_count_o = kill_q;

endmodule

// ==== logic/rvfi_shadow_pipe.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module rvfi_shadow_pipe import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,

    // Decoded instruction at ID
    input  logic      id_valid_i,
    input  word_t     id_instr_i,
    input  word_t     id_pc_i,
    input  reg_addr_t id_rs1_addr_i,
    input  logic      id_rs1_used_i,
    input  word_t     id_rs1_rdata_i,
    input  reg_addr_t id_rs2_addr_i,
    input  logic      id_rs2_used_i,
    input  word_t     id_rs2_rdata_i,
    input  reg_addr_t id_rd_addr_i,
    input  logic      id_rd_wen_i,
    input  word_t     id_rd_wdata_i,
    input  logic      id_branch_taken_i,
    input  word_t     id_branch_target_i,
    input  logic      id_trap_i,
    input  logic      id_mem_req_i,
    input  logic      id_mem_wen_i,
    input  word_t     id_mem_addr_i,
    input  byte_en_t  id_mem_ben_i,
    input  word_t     id_mem_wdata_i,
    input  word_t     id_mem_rdata_i,
    input  logic      id_csr_wen_i,
    input  word_t     id_csr_wdata_i,
    input  word_t     id_csr_rdata_i,

    // Controls and order count
    input  logic      pipe_stall_i,
    input  logic      ex_flush_i,
    input  logic      wb_bubble_i,
    input  logic      mark_intr_i,
    input  order_t    order_i,

    // Status to pipeline control
    output logic      ex_redirect_o,
    output logic      ex_is_trap_o,
    output logic      mem_is_access_o,

    // Retirement record
    output logic      rvfi_valid_o,
    output order_t    rvfi_order_o,
    output word_t     rvfi_insn_o,
    output logic      rvfi_trap_o,
    output logic      rvfi_intr_o,
    output reg_addr_t rvfi_rs1_addr_o,
    output word_t     rvfi_rs1_rdata_o,
    output reg_addr_t rvfi_rs2_addr_o,
    output word_t     rvfi_rs2_rdata_o,
    output reg_addr_t rvfi_rd_addr_o,
    output word_t     rvfi_rd_wdata_o,
    output word_t     rvfi_pc_rdata_o,
    output word_t     rvfi_pc_wdata_o,
    output word_t     rvfi_mem_addr_o,
    output byte_en_t  rvfi_mem_rmask_o,
    output byte_en_t  rvfi_mem_wmask_o,
    output word_t     rvfi_mem_rdata_o,
    output word_t     rvfi_mem_wdata_o,
    output word_t     rvfi_csr_rmask_o,
    output word_t     rvfi_csr_wmask_o,
    output word_t     rvfi_csr_wdata_o,
    output word_t     rvfi_csr_rdata_o
);

    logic      is_rvc_id;
    word_t     insn_id, pc_n_id;

    logic      valid_ex, trap_ex, intr_ex, taken_ex;
    word_t     insn_ex, pc_ex, pc_n_ex;
    reg_addr_t rs1_addr_ex, rs2_addr_ex, rd_addr_ex;
    word_t     rs1_rdata_ex, rs2_rdata_ex, rd_wdata_ex;
    logic      rd_wen_ex, mem_req_ex, mem_wen_ex, csr_wen_ex;
    word_t     mem_addr_ex, mem_wdata_ex, mem_rdata_ex, csr_wdata_ex, csr_rdata_ex;
    byte_en_t  mem_ben_ex;

    logic      valid_mem, trap_mem, intr_mem, rd_wen_mem, mem_req_mem;
    word_t     insn_mem, pc_mem, pc_n_mem;
    reg_addr_t rs1_addr_mem, rs2_addr_mem, rd_addr_mem;
    word_t     rs1_rdata_mem, rs2_rdata_mem, rd_wdata_mem;
    word_t     mem_addr_mem, mem_wdata_mem, mem_rdata_mem;
    byte_en_t  mem_rmask_mem, mem_wmask_mem;
    word_t     csr_rmask_mem, csr_wmask_mem, csr_wdata_mem, csr_rdata_mem;

    logic      valid_wb, rd_wen_wb;
    reg_addr_t rd_addr_wb;
    word_t     rd_wdata_wb;

    ////////////////////////////////////////////////////////////
    // ID: record fields known at decode
    ////////////////////////////////////////////////////////////

    assign is_rvc_id = (id_instr_i[1:0] != 2'b11);
    assign insn_id   = is_rvc_id ? {16'b0, id_instr_i[15:0]} : id_instr_i;

    // Trap vector wins over a taken branch
    always_comb begin
        if (id_trap_i) begin
            pc_n_id = `CORE_TRAP_VECTOR;
        end else if (id_branch_taken_i) begin
            pc_n_id = id_branch_target_i;
        end else begin
            pc_n_id = id_pc_i + (is_rvc_id ? word_t'(2) : word_t'(4));
        end
    end

    ////////////////////////////////////////////////////////////
    // ID -> EX
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_ex <= 1'b0;
        end else if (!pipe_stall_i) begin
            // Flushed instruction becomes a bubble
            valid_ex <= id_valid_i && !ex_flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!pipe_stall_i) begin
            insn_ex      <= insn_id;
            trap_ex      <= id_trap_i;
            taken_ex     <= id_branch_taken_i;
            intr_ex      <= mark_intr_i;
            // Sources only when the instruction reads them
            rs1_addr_ex  <= id_rs1_used_i ? id_rs1_addr_i : '0;
            rs1_rdata_ex <= id_rs1_used_i ? id_rs1_rdata_i : '0;
            rs2_addr_ex  <= id_rs2_used_i ? id_rs2_addr_i : '0;
            rs2_rdata_ex <= id_rs2_used_i ? id_rs2_rdata_i : '0;
            rd_addr_ex   <= id_rd_addr_i;
            rd_wen_ex    <= id_rd_wen_i;
            rd_wdata_ex  <= id_rd_wdata_i;
            pc_ex        <= id_pc_i;
            pc_n_ex      <= pc_n_id;
            mem_req_ex   <= id_mem_req_i;
            mem_wen_ex   <= id_mem_wen_i;
            mem_addr_ex  <= id_mem_addr_i;
            mem_ben_ex   <= id_mem_ben_i;
            mem_wdata_ex <= id_mem_wdata_i;
            mem_rdata_ex <= id_mem_rdata_i;
            csr_wen_ex   <= id_csr_wen_i;
            csr_wdata_ex <= id_csr_wdata_i;
            csr_rdata_ex <= id_csr_rdata_i;
        end
    end

    assign ex_redirect_o = valid_ex && (taken_ex || trap_ex);
    assign ex_is_trap_o  = valid_ex && trap_ex;

    ////////////////////////////////////////////////////////////
    // EX -> MEM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_mem <= 1'b0;
        end else if (!pipe_stall_i) begin
            valid_mem <= valid_ex;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!pipe_stall_i) begin
            insn_mem      <= insn_ex;
            trap_mem      <= trap_ex;
            intr_mem      <= intr_ex;
            rs1_addr_mem  <= rs1_addr_ex;
            rs1_rdata_mem <= rs1_rdata_ex;
            rs2_addr_mem  <= rs2_addr_ex;
            rs2_rdata_mem <= rs2_rdata_ex;
            rd_addr_mem   <= rd_addr_ex;
            rd_wen_mem    <= valid_ex && rd_wen_ex;
            rd_wdata_mem  <= rd_wdata_ex;
            pc_mem        <= pc_ex;
            pc_n_mem      <= pc_n_ex;
            mem_req_mem   <= valid_ex && mem_req_ex;
            mem_addr_mem  <= mem_addr_ex;
            mem_wdata_mem <= mem_wdata_ex;
            mem_rdata_mem <= mem_rdata_ex;
            // Loads and stores both read; only stores write
            mem_rmask_mem <= (valid_ex && mem_req_ex) ? mem_ben_ex : '0;
            mem_wmask_mem <= (valid_ex && mem_req_ex && mem_wen_ex) ? mem_ben_ex : '0;
            csr_rmask_mem <= {`CORE_XLEN{valid_ex}};
            csr_wmask_mem <= {`CORE_XLEN{valid_ex && csr_wen_ex}};
            csr_wdata_mem <= csr_wdata_ex;
            csr_rdata_mem <= csr_rdata_ex;
        end
    end

    assign mem_is_access_o = valid_mem && mem_req_mem;

    ////////////////////////////////////////////////////////////
    // MEM -> WB
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_wb <= 1'b0;
        end else begin
            valid_wb <= valid_mem && !wb_bubble_i;
        end
    end

    always_ff @(posedge clk_i) begin
        rvfi_insn_o      <= insn_mem;
        rvfi_trap_o      <= trap_mem;
        rvfi_intr_o      <= intr_mem;
        rvfi_rs1_addr_o  <= rs1_addr_mem;
        rvfi_rs1_rdata_o <= rs1_rdata_mem;
        rvfi_rs2_addr_o  <= rs2_addr_mem;
        rvfi_rs2_rdata_o <= rs2_rdata_mem;
        rd_addr_wb       <= rd_addr_mem;
        rd_wen_wb        <= rd_wen_mem;
        rd_wdata_wb      <= rd_wdata_mem;
        rvfi_pc_rdata_o  <= pc_mem;
        rvfi_pc_wdata_o  <= pc_n_mem;
        rvfi_mem_addr_o  <= mem_addr_mem;
        rvfi_mem_rmask_o <= mem_rmask_mem;
        rvfi_mem_wmask_o <= mem_wmask_mem;
        rvfi_mem_rdata_o <= mem_rdata_mem;
        rvfi_mem_wdata_o <= mem_wdata_mem;
        rvfi_csr_rmask_o <= csr_rmask_mem;
        rvfi_csr_wmask_o <= csr_wmask_mem;
        rvfi_csr_wdata_o <= csr_wdata_mem;
        rvfi_csr_rdata_o <= csr_rdata_mem;
    end

    // Destination only when written, x0 always reads zero
    assign rvfi_rd_addr_o  = rd_wen_wb ? rd_addr_wb : '0;
    assign rvfi_rd_wdata_o = (rvfi_rd_addr_o == '0) ? '0 : rd_wdata_wb;

    assign rvfi_valid_o = valid_wb;
    assign rvfi_order_o = order_i;

endmodule

// ==== logic/rvfi_trace_top.sv ====
`timescale 1ns/1ps

module rvfi_trace_top import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,

    // Instruction at ID
    input  logic      id_valid_i,
    input  word_t     id_instr_i,
    input  word_t     id_pc_i,
    input  reg_addr_t id_rs1_addr_i,
    input  logic      id_rs1_used_i,
    input  word_t     id_rs1_rdata_i,
    input  reg_addr_t id_rs2_addr_i,
    input  logic      id_rs2_used_i,
    input  word_t     id_rs2_rdata_i,
    input  reg_addr_t id_rd_addr_i,
    input  logic      id_rd_wen_i,
    input  word_t     id_rd_wdata_i,
    input  logic      id_branch_taken_i,
    input  word_t     id_branch_target_i,
    input  logic      id_trap_i,
    input  logic      id_mem_req_i,
    input  logic      id_mem_wen_i,
    input  word_t     id_mem_addr_i,
    input  byte_en_t  id_mem_ben_i,
    input  word_t     id_mem_wdata_i,
    input  word_t     id_mem_rdata_i,
    input  logic      id_csr_wen_i,
    input  word_t     id_csr_wdata_i,
    input  word_t     id_csr_rdata_i,
    input  logic      mem_busy_i,

    output logic      id_stall_o,

    // Retirement record
    output logic      rvfi_valid_o,
    output order_t    rvfi_order_o,
    output word_t     rvfi_insn_o,
    output logic      rvfi_trap_o,
    output logic      rvfi_intr_o,
    output reg_addr_t rvfi_rs1_addr_o,
    output word_t     rvfi_rs1_rdata_o,
    output reg_addr_t rvfi_rs2_addr_o,
    output word_t     rvfi_rs2_rdata_o,
    output reg_addr_t rvfi_rd_addr_o,
    output word_t     rvfi_rd_wdata_o,
    output word_t     rvfi_pc_rdata_o,
    output word_t     rvfi_pc_wdata_o,
    output word_t     rvfi_mem_addr_o,
    output byte_en_t  rvfi_mem_rmask_o,
    output byte_en_t  rvfi_mem_wmask_o,
    output word_t     rvfi_mem_rdata_o,
    output word_t     rvfi_mem_wdata_o,
    output word_t     rvfi_csr_rmask_o,
    output word_t     rvfi_csr_wmask_o,
    output word_t     rvfi_csr_wdata_o,
    output word_t     rvfi_csr_rdata_o,

    output kill_cnt_t kill_count_o
);

    logic   pipe_stall, ex_flush, wb_bubble, mark_intr, kill;
    logic   ex_redirect, ex_is_trap, mem_is_access;
    order_t order;

    // Source is held whenever the pipe is frozen
    assign id_stall_o = pipe_stall;

    pipe_ctrl_fsm u_ctrl (
        .*,
        .ex_redirect_i   (ex_redirect),
        .ex_is_trap_i    (ex_is_trap),
        .mem_is_access_i (mem_is_access),
        .pipe_stall_o    (pipe_stall),
        .ex_flush_o      (ex_flush),
        .wb_bubble_o     (wb_bubble),
        .mark_intr_o     (mark_intr),
        .kill_o          (kill),
        .state_o         ()
    );

    retire_counter u_count (
        .*,
        .retire_i (rvfi_valid_o),
        .kill_i   (kill),
        .order_o  (order)
    );

    rvfi_shadow_pipe u_shadow (
        .*,
        .pipe_stall_i    (pipe_stall),
        .ex_flush_i      (ex_flush),
        .wb_bubble_i     (wb_bubble),
        .mark_intr_i     (mark_intr),
        .order_i         (order),
        .ex_redirect_o   (ex_redirect),
        .ex_is_trap_o    (ex_is_trap),
        .mem_is_access_o (mem_is_access)
    );

endmodule

// ==== verif/rvfi_trace_chk.sv ====
`timescale 1ns/1ps

module rvfi_trace_chk import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,

    // Retirement record
    input  logic      valid_i,
    input  reg_addr_t rd_addr_i,
    input  word_t     rd_wdata_i,
    input  byte_en_t  rmask_i,
    input  byte_en_t  wmask_i,

    // Pipeline stall and the EX stage it freezes
    input  logic      stall_i,
    input  logic      ex_valid_i
);

    // Number of assertion failures
    int assert_fails = 0;

    // x0 never carries data
    a_rd_zero: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (valid_i && (rd_addr_i == '0)) |-> (rd_wdata_i == '0)
    ) else begin
        assert_fails++;
        $error("rd_wdata is nonzero for destination x0");
    end

    // Every written byte is also a read byte
    a_wmask_in_rmask: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        valid_i |-> ((wmask_i & ~rmask_i) == '0)
    ) else begin
        assert_fails++;
        $error("mem write mask has bytes outside the read mask");
    end

    // A stalled EX stage is neither flushed nor refilled
    a_no_flush_in_stall: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        stall_i |=> $stable(ex_valid_i)
    ) else begin
        assert_fails++;
        $error("EX stage changed across a stalled edge");
    end

endmodule

// Stall from pipe_ctrl_fsm, seen at the shadow pipe's input
bind rvfi_shadow_pipe rvfi_trace_chk u_chk (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (rvfi_valid_o),
    .rd_addr_i  (rvfi_rd_addr_o),
    .rd_wdata_i (rvfi_rd_wdata_o),
    .rmask_i    (rvfi_mem_rmask_o),
    .wmask_i    (rvfi_mem_wmask_o),
    .stall_i    (pipe_stall_i),
    .ex_valid_i (valid_ex)
);

// ==== verif/rvfi_trace_tb.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module rvfi_trace_tb import core_pkg::*; ();

    localparam int N_INSTR     = 300;
    localparam int CLK_PERIOD  = 10;
    localparam int RST_CYCLES  = 10;
    localparam int WATCHDOG_NS = (RST_CYCLES + N_INSTR * 12) * CLK_PERIOD;

    // Expected retirement record
    typedef struct {
        word_t     insn;
        logic      trap;
        logic      intr;
        reg_addr_t rs1_addr;
        word_t     rs1_rdata;
        reg_addr_t rs2_addr;
        word_t     rs2_rdata;
        reg_addr_t rd_addr;
        word_t     rd_wdata;
        word_t     pc_rdata;
        word_t     pc_wdata;
        word_t     mem_addr;
        byte_en_t  mem_rmask;
        byte_en_t  mem_wmask;
        word_t     mem_rdata;
        word_t     mem_wdata;
        word_t     csr_rmask;
        word_t     csr_wmask;
        word_t     csr_wdata;
        word_t     csr_rdata;
    } rec_t;

    logic      clk_i, rst_n_i, mem_busy_i;
    logic      id_valid_i, id_rs1_used_i, id_rs2_used_i, id_rd_wen_i;
    logic      id_branch_taken_i, id_trap_i, id_mem_req_i, id_mem_wen_i, id_csr_wen_i;
    word_t     id_instr_i, id_pc_i, id_rs1_rdata_i, id_rs2_rdata_i, id_rd_wdata_i;
    word_t     id_branch_target_i, id_mem_addr_i, id_mem_wdata_i, id_mem_rdata_i;
    word_t     id_csr_wdata_i, id_csr_rdata_i;
    reg_addr_t id_rs1_addr_i, id_rs2_addr_i, id_rd_addr_i;
    byte_en_t  id_mem_ben_i;

    logic      id_stall_o, rvfi_valid_o, rvfi_trap_o, rvfi_intr_o;
    order_t    rvfi_order_o;
    reg_addr_t rvfi_rs1_addr_o, rvfi_rs2_addr_o, rvfi_rd_addr_o;
    word_t     rvfi_insn_o, rvfi_rs1_rdata_o, rvfi_rs2_rdata_o, rvfi_rd_wdata_o;
    word_t     rvfi_pc_rdata_o, rvfi_pc_wdata_o, rvfi_mem_addr_o;
    word_t     rvfi_mem_rdata_o, rvfi_mem_wdata_o;
    byte_en_t  rvfi_mem_rmask_o, rvfi_mem_wmask_o;
    word_t     rvfi_csr_rmask_o, rvfi_csr_wmask_o, rvfi_csr_wdata_o, rvfi_csr_rdata_o;
    kill_cnt_t kill_count_o;

    // Model state
    rec_t        exp_q[$];
    logic [63:0] lcg_state;
    int          n_accepted, n_retired, exp_kills, errors, busy_left;
    logic        kill_next, intr_next;

    // Model view of the EX and MEM stages for the stall
    logic        exp_stall, enter_valid;
    logic        ex_st_valid, ex_st_req, mem_st_valid, mem_st_req;

    rvfi_trace_top DUT (.*);

    ////////////////////////////////////////////////////////////
    // Random source and compare
    ////////////////////////////////////////////////////////////

    function logic [31:0] rand_next();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state[63:32];
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic drive_next(input logic allow_valid);
        logic [31:0] r;
        r = rand_next();
        id_valid_i         <= allow_valid && (r[2:0] != 3'd0) && (n_accepted < N_INSTR);
        id_instr_i         <= rand_next();
        id_pc_i            <= rand_next() & 32'hffff_fffe;
        id_rs1_addr_i      <= r[7:3];
        id_rs1_used_i      <= r[8];
        id_rs1_rdata_i     <= rand_next();
        id_rs2_addr_i      <= r[13:9];
        id_rs2_used_i      <= r[14];
        id_rs2_rdata_i     <= rand_next();
        // Extra weight on x0 destinations
        id_rd_addr_i       <= (r[17:15] == 3'd0) ? 5'd0 : r[22:18];
        id_rd_wen_i        <= r[23];
        id_rd_wdata_i      <= rand_next();
        id_branch_taken_i  <= (r[26:24] == 3'd0);
        id_branch_target_i <= rand_next() & 32'hffff_fffe;
        id_trap_i          <= (r[29:27] == 3'd0);
        r = rand_next();
        id_mem_req_i       <= r[0];
        id_mem_wen_i       <= r[0] && r[1];
        id_mem_addr_i      <= rand_next();
        id_mem_ben_i       <= r[5:2];
        id_mem_wdata_i     <= rand_next();
        id_mem_rdata_i     <= rand_next();
        id_csr_wen_i       <= r[6];
        id_csr_wdata_i     <= rand_next();
        id_csr_rdata_i     <= rand_next();
    endtask

    // Busy bursts of 0 to 5 cycles
    task automatic drive_busy();
        logic [31:0] r;
        if (busy_left != 0) begin
            mem_busy_i <= 1'b1;
            busy_left--;
        end else begin
            mem_busy_i <= 1'b0;
            r = rand_next();
            if (r[1:0] == 2'd0) begin
                busy_left = r[4:2] % 6;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    task automatic model_accept();
        rec_t r;
        logic rvc;
        if (kill_next) begin
            // First accepted instruction after a redirect dies
            kill_next = 1'b0;
            exp_kills++;
        end else begin
            rvc         = (id_instr_i[1:0] != 2'b11);
            r.insn      = rvc ? {16'h0, id_instr_i[15:0]} : id_instr_i;
            r.trap      = id_trap_i;
            r.intr      = intr_next;
            r.rs1_addr  = id_rs1_used_i ? id_rs1_addr_i : 5'd0;
            r.rs1_rdata = id_rs1_used_i ? id_rs1_rdata_i : 32'd0;
            r.rs2_addr  = id_rs2_used_i ? id_rs2_addr_i : 5'd0;
            r.rs2_rdata = id_rs2_used_i ? id_rs2_rdata_i : 32'd0;
            r.rd_addr   = id_rd_wen_i ? id_rd_addr_i : 5'd0;
            r.rd_wdata  = (r.rd_addr == 5'd0) ? 32'd0 : id_rd_wdata_i;
            r.pc_rdata  = id_pc_i;
            if (id_trap_i) begin
                r.pc_wdata = `CORE_TRAP_VECTOR;
            end else if (id_branch_taken_i) begin
                r.pc_wdata = id_branch_target_i;
            end else begin
                r.pc_wdata = id_pc_i + (rvc ? 32'd2 : 32'd4);
            end
            r.mem_addr  = id_mem_addr_i;
            r.mem_rmask = id_mem_req_i ? id_mem_ben_i : 4'h0;
            r.mem_wmask = (id_mem_req_i && id_mem_wen_i) ? id_mem_ben_i : 4'h0;
            r.mem_rdata = id_mem_rdata_i;
            r.mem_wdata = id_mem_wdata_i;
            r.csr_rmask = 32'hffff_ffff;
            r.csr_wmask = id_csr_wen_i ? 32'hffff_ffff : 32'h0;
            r.csr_wdata = id_csr_wdata_i;
            r.csr_rdata = id_csr_rdata_i;
            exp_q.push_back(r);
            intr_next = 1'b0;
            if (id_branch_taken_i || id_trap_i) begin
                kill_next = 1'b1;
            end
            // Handler entry is the next survivor
            if (id_trap_i) begin
                intr_next = 1'b1;
            end
        end
    endtask

    task automatic check_record();
        rec_t e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Retirement at %0t ns with no instruction left in the model", $time);
        end else begin
            e = exp_q.pop_front();
            check_val("order", rvfi_order_o, n_retired);
            check_val("insn", rvfi_insn_o, e.insn);
            check_val("trap", rvfi_trap_o, e.trap);
            check_val("intr", rvfi_intr_o, e.intr);
            check_val("rs1_addr", rvfi_rs1_addr_o, e.rs1_addr);
            check_val("rs1_rdata", rvfi_rs1_rdata_o, e.rs1_rdata);
            check_val("rs2_addr", rvfi_rs2_addr_o, e.rs2_addr);
            check_val("rs2_rdata", rvfi_rs2_rdata_o, e.rs2_rdata);
            check_val("rd_addr", rvfi_rd_addr_o, e.rd_addr);
            check_val("rd_wdata", rvfi_rd_wdata_o, e.rd_wdata);
            check_val("pc_rdata", rvfi_pc_rdata_o, e.pc_rdata);
            check_val("pc_wdata", rvfi_pc_wdata_o, e.pc_wdata);
            check_val("mem_addr", rvfi_mem_addr_o, e.mem_addr);
            check_val("mem_rmask", rvfi_mem_rmask_o, e.mem_rmask);
            check_val("mem_wmask", rvfi_mem_wmask_o, e.mem_wmask);
            check_val("mem_rdata", rvfi_mem_rdata_o, e.mem_rdata);
            check_val("mem_wdata", rvfi_mem_wdata_o, e.mem_wdata);
            check_val("csr_rmask", rvfi_csr_rmask_o, e.csr_rmask);
            check_val("csr_wmask", rvfi_csr_wmask_o, e.csr_wmask);
            check_val("csr_wdata", rvfi_csr_wdata_o, e.csr_wdata);
            check_val("csr_rdata", rvfi_csr_rdata_o, e.csr_rdata);
            n_retired++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Clock, per-edge driver and monitor
    ////////////////////////////////////////////////////////////

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk_i = ~clk_i;
        end
    end

    // Values read here are the ones held through the cycle just ended
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            if (rvfi_valid_o) begin
                check_record();
            end
            // Busy memory with an access sitting in MEM
            exp_stall = mem_st_valid && mem_st_req && mem_busy_i;
            check_val("id_stall", id_stall_o, exp_stall);
            enter_valid = 1'b0;
            if (id_valid_i && !id_stall_o) begin
                enter_valid = !kill_next;
                model_accept();
                n_accepted++;
            end
            if (!exp_stall) begin
                mem_st_valid = ex_st_valid;
                mem_st_req   = ex_st_req;
                ex_st_valid  = enter_valid;
                ex_st_req    = id_mem_req_i;
            end
            // Source holds its fields while stalled
            if (!id_stall_o) begin
                drive_next(1'b1);
            end
            drive_busy();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the pipeline did not drain", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        lcg_state    = 64'd64;
        n_accepted   = 0;
        n_retired    = 0;
        exp_kills    = 0;
        errors       = 0;
        busy_left    = 0;
        kill_next    = 1'b0;
        intr_next    = 1'b0;
        exp_stall    = 1'b0;
        enter_valid  = 1'b0;
        ex_st_valid  = 1'b0;
        ex_st_req    = 1'b0;
        mem_st_valid = 1'b0;
        mem_st_req   = 1'b0;
        rst_n_i      = 1'b0;
        mem_busy_i   = 1'b0;
        // Random fields with valid low
        drive_next(1'b0);
        repeat (RST_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;

        wait (n_accepted >= N_INSTR);
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        // Room for any stray record
        repeat (10) @(posedge clk_i);

        check_val("kill_count", kill_count_o, exp_kills);
        errors += DUT.u_shadow.u_chk.assert_fails;
        $display("Summary: %0d errors, %0d retired, %0d killed", errors, n_retired, exp_kills);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+logic
logic/core_pkg.sv
logic/pipe_ctrl_fsm.sv
logic/retire_counter.sv
logic/rvfi_shadow_pipe.sv
logic/rvfi_trace_top.sv
verif/rvfi_trace_chk.sv
verif/rvfi_trace_tb.sv

// ==== Bender.yml ====
package:
  name: rvfi_trace

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/core_pkg.sv
      - logic/pipe_ctrl_fsm.sv
      - logic/retire_counter.sv
      - logic/rvfi_shadow_pipe.sv
      - logic/rvfi_trace_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - verif/rvfi_trace_chk.sv
      - verif/rvfi_trace_tb.sv
